// File: project.f
+incdir+logic
logic/cache_pkg.sv
logic/cache_way.sv
logic/plru_tree.sv
logic/cache_ctrl.sv
logic/reconfig_cache.sv
tb/clock_gen.sv
tb/reconfig_cache_props.sv
tb/reconfig_cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= reconfig_cache_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/reconfig_cache_tb.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module reconfig_cache_tb
    import cache_pkg::*;
();

    localparam int          resp_limit  = 200;
    localparam int          flush_limit = 4000;
    localparam logic [31:0] seed        = 32'h3909_7b9b;

    logic        clk;
    logic        rst;
    addr_t       ufp_addr;
    mask_t       ufp_rmask;
    mask_t       ufp_wmask;
    word_t       ufp_wdata;
    word_t       ufp_rdata;
    logic        ufp_resp;
    addr_t       dfp_addr;
    logic        dfp_read;
    logic        dfp_write;
    line_t       dfp_wdata;
    line_t       dfp_rdata;
    logic        dfp_resp;
    assoc_mode_t mode_sel;
    logic        mode_load;
    assoc_mode_t mode;

    line_t       mem_lines [addr_t];   // lines written back by the DUT
    word_t       shadow [addr_t];      // expected words after cpu writes
    addr_t       wr_log [$];
    int          n_reads;
    int          errors;
    logic [31:0] rng;

    clock_gen clk_inst (
        .clk (clk),
        .rst (rst)
    );

    reconfig_cache reconfig_cache_inst (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t next_rand();
        rng = lcg_next(rng);
        return rng;
    endfunction

    // power-up memory contents keyed by word address
    function automatic word_t init_word(input addr_t a);
        return lcg_next(lcg_next(seed ^ {a[31:2], 2'b00}));
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return {a[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
    endfunction

    function automatic line_t memory_line(input addr_t a);
        line_t l;
        if (mem_lines.exists(a))
            return mem_lines[a];
        for (int w = 0; w < 8; w++)
            l[w*32 +: 32] = init_word(a + addr_t'(w*4));
        return l;
    endfunction

    function automatic word_t expected_word(input addr_t a);
        addr_t wa;
        wa = {a[31:2], 2'b00};
        if (shadow.exists(wa))
            return shadow[wa];
        return init_word(wa);
    endfunction

    function automatic line_t expected_line(input addr_t a);
        line_t l;
        for (int w = 0; w < 8; w++)
            l[w*32 +: 32] = expected_word(line_of(a) + addr_t'(w*4));
        return l;
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t nw, input mask_t m);
        word_t r;
        r = old;
        for (int b = 0; b < 4; b++)
            if (m[b])
                r[b*8 +: 8] = nw[b*8 +: 8];
        return r;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("error %0t: %s got %h expected %h", $time, what, got, exp);
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("error %0t: %s", $time, what);
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout: no %s within the cycle limit", what);
        $display("sim failed");
        $finish;
    endtask

    // memory model answers 3 cycles after a request is seen
    initial begin
        addr_t a;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        n_reads   = 0;
        forever begin
            @(negedge clk);
            if (rst === 1'b0 && (dfp_read || dfp_write)) begin
                a = dfp_addr;
                if (dfp_write) begin
                    mem_lines[a] = dfp_wdata;
                    wr_log.push_back(a);
                end else begin
                    n_reads++;
                end
                repeat (3) @(posedge clk);
                dfp_resp  <= 1'b1;
                dfp_rdata <= memory_line(a);
                @(posedge clk);
                dfp_resp  <= 1'b0;
            end
        end
    end

    // lat counts the cycles from the first cycle the mask is seen
    task automatic cpu_access(input addr_t a, input mask_t rm, input mask_t wm,
                              input word_t wd, output word_t rd, output int lat);
        logic done;
        done = 1'b0;
        lat  = 0;
        rd   = '0;
        @(posedge clk);
        ufp_addr  <= a;
        ufp_rmask <= rm;
        ufp_wmask <= wm;
        ufp_wdata <= wd;
        while (!done && lat < resp_limit) begin
            @(negedge clk);
            if (ufp_resp === 1'b1) begin
                done = 1'b1;
                rd   = ufp_rdata;
            end else begin
                lat++;
            end
        end
        if (!done)
            timeout_abort("ufp_resp");
        @(posedge clk);
        ufp_rmask <= '0;
        ufp_wmask <= '0;
    endtask

    task automatic read_check(input addr_t a, output int lat);
        word_t rd;
        word_t exp;
        exp = expected_word(a);
        cpu_access(a, 4'hf, 4'h0, '0, rd, lat);
        if (rd !== exp)
            report_mismatch($sformatf("read %h", a), rd, exp);
    endtask

    task automatic write_word(input addr_t a, input word_t wd, input mask_t m, output int lat);
        word_t rd;
        cpu_access(a, 4'h0, m, wd, rd, lat);
        shadow[{a[31:2], 2'b00}] = merge_bytes(expected_word(a), wd, m);
    endtask

    task automatic change_mode(input assoc_mode_t m);
        int n;
        @(posedge clk);
        mode_sel  <= m;
        mode_load <= 1'b1;
        @(posedge clk);
        mode_load <= 1'b0;
        n = 0;
        while (mode !== m && n < flush_limit) begin
            @(negedge clk);
            n++;
        end
        if (mode !== m)
            timeout_abort("mode change");
    endtask

    task automatic read_miss_then_hit();
        addr_t a;
        int    lat;
        int    reads0;
        a      = 32'h0000_1044;
        reads0 = n_reads;
        read_check(a, lat);
        if (n_reads != reads0 + 1)
            report_error("read miss did not issue exactly one dfp read");
        reads0 = n_reads;
        read_check(a, lat);
        if (n_reads != reads0)
            report_error("read hit issued a dfp read");
        if (lat != 2)
            report_mismatch("read hit latency", lat, 2);
    endtask

    task automatic byte_write_merge();
        addr_t a;
        word_t wd;
        word_t old;
        word_t exp;
        word_t rd;
        int    lat;
        int    reads0;
        a      = 32'h0000_1048;   // same line as the read test
        wd     = next_rand();
        old    = expected_word(a);
        reads0 = n_reads;
        write_word(a, wd, 4'b0101, lat);
        if (n_reads != reads0)
            report_error("write hit issued a dfp read");
        if (lat != 2)
            report_mismatch("write hit latency", lat, 2);
        exp = merge_bytes(old, wd, 4'b0101);
        cpu_access(a, 4'hf, 4'h0, '0, rd, lat);
        if (rd !== exp)
            report_mismatch("merged word", rd, exp);
    endtask

    task automatic evict_in_4way();
        addr_t a [5];
        addr_t wa;
        logic  known;
        int    writes0;
        int    lat;
        writes0 = wr_log.size();
        for (int k = 0; k < 5; k++) begin
            a[k] = 32'h0001_00a4 + addr_t'(k) * 32'h200;   // all in set 5
            write_word(a[k], next_rand(), 4'hf, lat);
        end
        if (wr_log.size() != writes0 + 1) begin
            report_error($sformatf("eviction gave %0d dfp writes", wr_log.size() - writes0));
        end else begin
            wa    = wr_log[writes0];
            known = 1'b0;
            for (int k = 0; k < 4; k++)
                if (wa == line_of(a[k]))
                    known = 1'b1;
            if (!known)
                report_error($sformatf("eviction wrote unexpected line %h", wa));
            if (mem_lines[wa] !== expected_line(wa))
                report_error($sformatf("eviction data wrong for line %h", wa));
        end
        for (int k = 0; k < 5; k++)
            read_check(a[k], lat);
    endtask

    task automatic direct_mapped_conflict();
        addr_t a0;
        addr_t a1;
        int    lat;
        int    reads0;
        a0 = 32'h0002_00e0;   // both in set 7
        a1 = 32'h0003_40e8;
        change_mode(mode_dm);
        for (int i = 0; i < 4; i++) begin
            reads0 = n_reads;
            read_check((i % 2 == 0) ? a0 : a1, lat);
            if (n_reads != reads0 + 1)
                report_error($sformatf("direct-mapped access %0d did not miss", i));
        end
        change_mode(mode_2way);
        reads0 = n_reads;
        for (int i = 0; i < 4; i++)
            read_check((i % 2 == 0) ? a0 : a1, lat);
        if (n_reads != reads0 + 2)
            report_mismatch("2-way dfp reads", n_reads - reads0, 2);
    endtask

    task automatic flush_on_mode_change();
        addr_t a [4];
        int    writes0;
        int    reads0;
        int    hits;
        int    lat;
        for (int k = 0; k < 4; k++) begin
            a[k] = 32'h0004_0008 + addr_t'(k*3 + 1) * 32'h20;   // sets 1, 4, 7, 10
            write_word(a[k], next_rand(), 4'hf, lat);
        end
        writes0 = wr_log.size();
        change_mode(mode_4way);
        if (wr_log.size() - writes0 != 4)
            report_mismatch("flush dfp writes", wr_log.size() - writes0, 4);
        for (int k = 0; k < 4; k++) begin
            hits = 0;
            for (int i = writes0; i < wr_log.size(); i++)
                if (wr_log[i] == line_of(a[k]))
                    hits++;
            if (hits != 1)
                report_error($sformatf("line %h written back %0d times", line_of(a[k]), hits));
            else if (mem_lines[line_of(a[k])] !== expected_line(a[k]))
                report_error($sformatf("flush data wrong for line %h", line_of(a[k])));
        end
        for (int k = 0; k < 4; k++) begin
            reads0 = n_reads;
            read_check(a[k], lat);
            if (n_reads != reads0 + 1)
                report_error($sformatf("access to %h hit after the flush", a[k]));
        end
    endtask

    initial begin
        int n;
        ufp_addr  = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        mode_sel  = mode_4way;
        mode_load = 1'b0;
        errors    = 0;
        rng       = seed;
        n = 0;
        while (rst !== 1'b0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0)
            timeout_abort("reset release");
        @(negedge clk);
        if (mode !== mode_4way)
            report_mismatch("mode after reset", mode, mode_4way);
        if (ufp_resp !== 1'b0 || dfp_read !== 1'b0 || dfp_write !== 1'b0)
            report_error("handshake outputs not low after reset");

        read_miss_then_hit();
        byte_write_merge();
        evict_in_4way();
        direct_mapped_conflict();
        flush_on_mode_change();

        $display("errors %0d", errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: tb/reconfig_cache_props.sv
`timescale 1ns/1ns

module reconfig_cache_props
    import cache_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input mask_t ufp_rmask,
    input mask_t ufp_wmask,
    input logic  ufp_resp,
    input logic  dfp_read,
    input logic  dfp_write,
    input logic  flushing
);

    logic [6:0] wait_cnt;   // cycles an open request has waited

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wait_cnt <= '0;
        else if (((|ufp_rmask) || (|ufp_wmask)) && !ufp_resp)
            wait_cnt <= wait_cnt + 7'd1;
        else
            wait_cnt <= '0;
    end

    no_read_write: assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write))
        else $error("dfp_read and dfp_write high in the same cycle");

    resp_pulse: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |=> !ufp_resp)
        else $error("ufp_resp held for more than one cycle");

    resp_in_time: assert property (@(posedge clk) disable iff (rst)
        wait_cnt <= 7'd64)
        else $error("request not answered within 64 cycles");

    no_resp_in_flush: assert property (@(posedge clk) disable iff (rst)
        !(ufp_resp && flushing))
        else $error("ufp_resp during a flush");

endmodule

bind reconfig_cache reconfig_cache_props props_inst (
    .clk       (clk),
    .rst       (rst),
    .ufp_rmask (ufp_rmask),
    .ufp_wmask (ufp_wmask),
    .ufp_resp  (ufp_resp),
    .dfp_read  (dfp_read),
    .dfp_write (dfp_write),
    .flushing  (flushing)
);

// File: tb/clock_gen.sv
`timescale 1ns/1ns

module clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: logic/reconfig_cache.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module reconfig_cache
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // cpu side
    input  addr_t       ufp_addr,
    input  mask_t       ufp_rmask,
    input  mask_t       ufp_wmask,
    input  word_t       ufp_wdata,
    output word_t       ufp_rdata,
    output logic        ufp_resp,

    // memory side
    output addr_t       dfp_addr,
    output logic        dfp_read,
    output logic        dfp_write,
    output line_t       dfp_wdata,
    input  line_t       dfp_rdata,
    input  logic        dfp_resp,

    input  assoc_mode_t mode_sel,
    input  logic        mode_load,
    output assoc_mode_t mode
);

    cpu_req_t               req_q;
    logic                   req_valid;
    logic                   busy_idle;
    tag_t                   req_tag;
    set_idx_t               req_set;
    logic [2:0]             req_word;
    set_idx_t               cur_set;
    way_entry_t             entries [`CACHE_WAYS];
    way_entry_t             hit_entry;
    way_entry_t             sel_entry;
    way_idx_t               sel_way;
    logic                   sel_dirty;
    logic [`CACHE_WAYS-1:0] active;
    logic                   hit;
    way_idx_t               hit_way;
    way_idx_t               victim;
    logic                   fill;
    logic                   cpu_write;
    logic                   touch;
    logic                   flushing;
    set_idx_t               flush_set;
    way_idx_t               flush_way;
    logic                   clean;
    logic                   invalidate;

    assign req_valid = (|ufp_rmask) || (|ufp_wmask);

    always_ff @(posedge clk) begin
        if (busy_idle && req_valid)
            req_q <= '{addr: ufp_addr, rmask: ufp_rmask, wmask: ufp_wmask, wdata: ufp_wdata};
    end

    assign req_tag  = req_q.addr[31 -: `TAG_BITS];
    assign req_set  = req_q.addr[`OFFSET_BITS +: `SET_BITS];
    assign req_word = req_q.addr[`OFFSET_BITS-1:2];
    assign cur_set  = flushing ? flush_set : req_set;

    for (genvar i = 0; i < `CACHE_WAYS; i++) begin : g_way
        cache_way u_way (
            .clk        (clk),
            .rst        (rst),
            .set        (cur_set),
            .fill       (fill && (victim == way_idx_t'(i))),
            .line_in    (dfp_rdata),
            .tag_in     (req_tag),
            .word_we    (cpu_write && (hit_way == way_idx_t'(i))),
            .word_sel   (req_word),
            .wdata      (req_q.wdata),
            .wmask      (req_q.wmask),
            .clean      (clean && (flush_way == way_idx_t'(i))),
            .invalidate (invalidate),
            .entry      (entries[i])
        );
    end

    always_comb begin
        case (mode)
            mode_dm:   active = 4'b0001;
            mode_2way: active = 4'b0011;
            default:   active = 4'b1111;
        endcase
    end

    // tag compare over the active ways only
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < `CACHE_WAYS; i++) begin
            if (active[i] && entries[i].valid && (entries[i].tag == req_tag)) begin
                hit     = 1'b1;
                hit_way = way_idx_t'(i);
            end
        end
    end

    assign hit_entry = entries[hit_way];
    assign ufp_rdata = hit_entry.data[req_word*32 +: 32];   // after a fill this is the new line

    // victim on a miss or the visited entry during a flush
    assign sel_way   = flushing ? flush_way : victim;
    assign sel_entry = entries[sel_way];
    assign sel_dirty = sel_entry.valid && sel_entry.dirty;
    assign dfp_wdata = sel_entry.data;

    always_comb begin
        if (dfp_write)
            dfp_addr = {sel_entry.tag, cur_set, {`OFFSET_BITS{1'b0}}};
        else
            dfp_addr = {req_q.addr[31:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
    end

    plru_tree u_plru (
        .clk       (clk),
        .rst       (rst),
        .set       (req_set),
        .mode      (mode),
        .touch     (touch),
        .touch_way (hit_way),
        .victim    (victim)
    );

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .is_write     (|req_q.wmask),
        .hit          (hit),
        .victim_dirty (sel_dirty),
        .dfp_resp     (dfp_resp),
        .mode_sel     (mode_sel),
        .mode_load    (mode_load),
        .flush_dirty  (sel_dirty),
        .busy_idle    (busy_idle),
        .dfp_read     (dfp_read),
        .dfp_write    (dfp_write),
        .fill         (fill),
        .cpu_write    (cpu_write),
        .ufp_resp     (ufp_resp),
        .touch        (touch),
        .flushing     (flushing),
        .flush_set    (flush_set),
        .flush_way    (flush_way),
        .clean        (clean),
        .invalidate   (invalidate),
        .mode         (mode)
    );

endmodule

// File: logic/cache_ctrl.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_ctrl
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  logic        is_write,
    input  logic        hit,
    input  logic        victim_dirty,
    input  logic        dfp_resp,
    input  assoc_mode_t mode_sel,
    input  logic        mode_load,
    input  logic        flush_dirty,
    output logic        busy_idle,
    output logic        dfp_read,
    output logic        dfp_write,
    output logic        fill,
    output logic        cpu_write,
    output logic        ufp_resp,
    output logic        touch,
    output logic        flushing,
    output set_idx_t    flush_set,
    output way_idx_t    flush_way,
    output logic        clean,
    output logic        invalidate,
    output assoc_mode_t mode
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    assoc_mode_t mode_q;
    assoc_mode_t pend_mode_q;
    logic        pend_valid_q;
    logic        flush_last;
    logic        flush_step;

    assign flush_last = (flush_set == set_idx_t'(`CACHE_SETS - 1)) &&
                        (flush_way == way_idx_t'(`CACHE_WAYS - 1));
    assign flush_step = (state_q == st_flush_chk && !flush_dirty) ||
                        (state_q == st_flush_wb && dfp_resp);

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (pend_valid_q)
                    state_d = st_flush_chk;   // request waits for the flush
                else if (req_valid)
                    state_d = st_lookup;
            end
            st_lookup: begin
                if (hit)
                    state_d = st_resp;
                else
                    state_d = victim_dirty ? st_wb : st_fill;
            end
            st_wb:   if (dfp_resp) state_d = st_fill;
            st_fill: if (dfp_resp) state_d = st_resp;
            st_resp: state_d = st_idle;
            st_flush_chk: begin
                if (flush_dirty)
                    state_d = st_flush_wb;
                else if (flush_last)
                    state_d = st_flush_done;
            end
            st_flush_wb: begin
                if (dfp_resp)
                    state_d = flush_last ? st_flush_done : st_flush_chk;
            end
            default: state_d = st_idle;      // flush_done
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= st_idle;
            flush_set <= '0;
            flush_way <= '0;
        end else begin
            state_q <= state_d;
            if (flush_step)
                {flush_set, flush_way} <= {flush_set, flush_way} + 1'b1;  // wraps at end
        end
    end

    // a later strobe overrides the pending mode
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode_q       <= mode_4way;
            pend_mode_q  <= mode_4way;
            pend_valid_q <= 1'b0;
        end else begin
            if (state_q == st_flush_done) begin
                mode_q       <= pend_mode_q;
                pend_valid_q <= 1'b0;
            end
            if (mode_load) begin
                pend_mode_q  <= mode_sel;
                pend_valid_q <= 1'b1;
            end
        end
    end

    assign busy_idle  = (state_q == st_idle);
    assign dfp_read   = (state_q == st_fill);
    assign dfp_write  = (state_q == st_wb) || (state_q == st_flush_wb);
    assign fill       = (state_q == st_fill) && dfp_resp;
    assign ufp_resp   = (state_q == st_resp);
    assign cpu_write  = ufp_resp && is_write;
    assign touch      = ufp_resp;
    assign flushing   = (state_q == st_flush_chk) || (state_q == st_flush_wb) ||
                        (state_q == st_flush_done);
    assign clean      = (state_q == st_flush_wb) && dfp_resp;
    assign invalidate = (state_q == st_flush_done);
    assign mode       = mode_q;

endmodule

// File: logic/plru_tree.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module plru_tree
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  set_idx_t    set,
    input  assoc_mode_t mode,
    input  logic        touch,
    input  way_idx_t    touch_way,
    output way_idx_t    victim
);

    // bit 0 root, bit 1 picks within ways 0/1, bit 2 within ways 2/3
    logic [2:0] tree_q [`CACHE_SETS];
    logic [2:0] cur;

    assign cur = tree_q[set];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            tree_q[set][0] <= ~touch_way[1];   // root points to other half
            if (touch_way[1])
                tree_q[set][2] <= ~touch_way[0];
            else
                tree_q[set][1] <= ~touch_way[0];
        end
    end

    always_comb begin
        case (mode)
            mode_dm: begin
                victim = 2'd0;
            end
            mode_2way: begin
                victim = cur[1] ? 2'd1 : 2'd0;
            end
            default: begin
                if (cur[0])
                    victim = cur[2] ? 2'd3 : 2'd2;
                else
                    victim = cur[1] ? 2'd1 : 2'd0;
            end
        endcase
    end

endmodule

// File: logic/cache_way.sv
`timescale 1ns/1ns
`include "cache_cfg.svh"

module cache_way
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  set_idx_t   set,
    input  logic       fill,
    input  line_t      line_in,
    input  tag_t       tag_in,
    input  logic       word_we,
    input  logic [2:0] word_sel,
    input  word_t      wdata,
    input  mask_t      wmask,
    input  logic       clean,
    input  logic       invalidate,
    output way_entry_t entry
);

    line_t                  data_mem [`CACHE_SETS];
    tag_t                   tag_mem  [`CACHE_SETS];
    logic [`CACHE_SETS-1:0] valid_q;
    logic [`CACHE_SETS-1:0] dirty_q;

    always_ff @(posedge clk) begin
        if (fill) begin
            data_mem[set] <= line_in;
            tag_mem[set]  <= tag_in;
        end else if (word_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b])
                    data_mem[set][word_sel*32 + b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (invalidate)
                valid_q <= '0;
            else if (fill)
                valid_q[set] <= 1'b1;

            if (fill)
                dirty_q[set] <= 1'b0;     // fresh line from memory
            else if (word_we)
                dirty_q[set] <= 1'b1;
            else if (clean)
                dirty_q[set] <= 1'b0;     // written back by flush
        end
    end

    always_comb begin
        entry.valid = valid_q[set];
        entry.dirty = dirty_q[set];
        entry.tag   = tag_mem[set];
        entry.data  = data_mem[set];
    end

endmodule

// File: logic/cache_pkg.sv
`include "cache_cfg.svh"

package cache_pkg;

    typedef logic [31:0]             addr_t;
    typedef logic [31:0]             word_t;
    typedef logic [`LINE_BITS-1:0]   line_t;
    typedef logic [`TAG_BITS-1:0]    tag_t;
    typedef logic [`SET_BITS-1:0]    set_idx_t;
    typedef logic [1:0]              way_idx_t;
    typedef logic [3:0]              mask_t;

    // 1, 2 or 4 active ways
    typedef enum logic [1:0] {
        mode_dm   = 2'd0,
        mode_2way = 2'd1,
        mode_4way = 2'd2
    } assoc_mode_t;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_wb,
        st_fill,
        st_resp,
        st_flush_chk,
        st_flush_wb,
        st_flush_done
    } ctrl_state_t;

    typedef struct packed {
        addr_t addr;
        mask_t rmask;
        mask_t wmask;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        line_t data;
    } way_entry_t;

endpackage

// File: logic/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// geometry
`define CACHE_SETS   16
`define CACHE_WAYS   4

// address fields
`define SET_BITS     4
`define OFFSET_BITS  5   // byte offset in a 32-byte line
`define TAG_BITS     23

// dfp line width
`define LINE_BITS    256

`endif
